/* ciHub_params.svh */
// Custom-instruction hub constants: instruction numbers, counter layout and delay scaling
`ifndef CIHUB_PARAMS_SVH
`define CIHUB_PARAMS_SVH

// Instruction numbers as seen on ciN
`define CI_GRAY_ID              8'd12
`define CI_PROFILE_ID           8'd11
`define CI_DELAY_ID             8'd6

// Profile unit layout
`define PROFILE_COUNTERS        4

// Command fields in operand B, one bit per counter
`define PROFILE_ENABLE_LSB      0
`define PROFILE_DISABLE_LSB     4
`define PROFILE_CLEAR_LSB       8

// 40 ns system clock
`define CLOCKS_PER_MICROSECOND  32'd25

// Luma weights, scaled by 256
`define GRAY_RED_WEIGHT         16'd54
`define GRAY_GREEN_WEIGHT       16'd183
`define GRAY_BLUE_WEIGHT        16'd19

`endif

/* ciHubPkg.sv */
// Shared types of the custom-instruction hub and its units
package ciHubPkg;

  // Custom-instruction number
  typedef logic [7:0] ciId_t;

  // Operand or result word
  typedef logic [31:0] ciWord_t;

  // One profile counter
  typedef logic [31:0] counterValue_t;

  // Gray level
  typedef logic [7:0] grayValue_t;

  // Delay unit FSM
  typedef enum logic {
    delayIdle,
    delayCounting
  } delayState_t;

endpackage

/* ciRequestIf.sv */
// Request path from the hub to the custom-instruction units
`timescale 1ns/1ps

interface ciRequestIf;
  import ciHubPkg::*;

  logic    start;
  ciId_t   n;
  ciWord_t dataA;
  ciWord_t dataB;

  // Hub side
  modport host (
    output start,
    output n,
    output dataA,
    output dataB
  );

  // Unit side
  modport unit (
    input start,
    input n,
    input dataA,
    input dataB
  );

endinterface

/* grayscaleIse.sv */
// Grayscale instruction: RGB565 pixel to 8-bit gray level in a single cycle
`timescale 1ns/1ps
`include "ciHub_params.svh"

module grayscaleIse (
  ciRequestIf.unit            request,
  output logic                done,
  output ciHubPkg::ciWord_t   result
);
  import ciHubPkg::*;

  logic [15:0] pixel;
  logic [7:0]  redWide;
  logic [7:0]  greenWide;
  logic [7:0]  blueWide;
  logic [15:0] weightedSum;
  grayValue_t  grayLevel;
  logic        hit;

  assign hit = request.start && (request.n == `CI_GRAY_ID);

  assign pixel = request.dataA[15:0];

  // Widen each channel to 8 bits
  assign redWide   = {pixel[15:11], 3'b000};
  assign greenWide = {pixel[10:5], 2'b00};
  assign blueWide  = {pixel[4:0], 3'b000};

  // Weights sum to 256, so the total stays within 16 bits
  assign weightedSum = `GRAY_RED_WEIGHT * redWide +
                       `GRAY_GREEN_WEIGHT * greenWide +
                       `GRAY_BLUE_WEIGHT * blueWide;

  assign grayLevel = weightedSum[15:8];

  assign done   = hit;
  assign result = hit ? ciWord_t'(grayLevel) : '0;

endmodule

/* profileCounters.sv */
// Profile instruction: four enable/disable/clear counters with single-cycle read-out
`timescale 1ns/1ps
`include "ciHub_params.svh"

module profileCounters (
  input  logic                s_systemClock,
  input  logic                s_pllLocked,
  ciRequestIf.unit            request,
  input  logic                cpuStall,
  input  logic                busIdle,
  output logic                done,
  output ciHubPkg::ciWord_t   result
);
  import ciHubPkg::*;

  counterValue_t                 counters [`PROFILE_COUNTERS];
  logic [`PROFILE_COUNTERS-1:0]  counterEnabled;
  logic [`PROFILE_COUNTERS-1:0]  countTick;
  logic [`PROFILE_COUNTERS-1:0]  enableMask;
  logic [`PROFILE_COUNTERS-1:0]  disableMask;
  logic [`PROFILE_COUNTERS-1:0]  clearMask;
  counterValue_t                 selectedCount;
  logic                          hit;

  assign hit = request.start && (request.n == `CI_PROFILE_ID);

  // Command masks only count in a start cycle for this unit
  assign enableMask  = hit ? request.dataB[`PROFILE_ENABLE_LSB +: `PROFILE_COUNTERS] : '0;
  assign disableMask = hit ? request.dataB[`PROFILE_DISABLE_LSB +: `PROFILE_COUNTERS] : '0;
  assign clearMask   = hit ? request.dataB[`PROFILE_CLEAR_LSB +: `PROFILE_COUNTERS] : '0;

  // Events: cycles, stalls, bus idle, cycles again
  assign countTick = {1'b1, busIdle, cpuStall, 1'b1};

  // Disable wins over enable
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      counterEnabled <= '0;
    end else begin
      counterEnabled <= (counterEnabled | enableMask) & ~disableMask;
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
        counters[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `PROFILE_COUNTERS; i++) begin
        // Clear has priority over the count of the same edge
        if (clearMask[i]) begin
          counters[i] <= '0;
        end else if (counterEnabled[i] && countTick[i]) begin
          counters[i] <= counters[i] + 1'b1;
        end
      end
    end
  end

  // Counter select in operand A bits 1..0
  assign selectedCount = counters[request.dataA[1:0]];

  assign done   = hit;
  assign result = hit ? ciWord_t'(selectedCount) : '0;

endmodule

/* microDelayIse.sv */
// Delay instruction: blocks for operand A microseconds, then pulses done
`timescale 1ns/1ps
`include "ciHub_params.svh"

module microDelayIse (
  input  logic                s_systemClock,
  input  logic                s_pllLocked,
  ciRequestIf.unit            request,
  output logic                done,
  output ciHubPkg::ciWord_t   result
);
  import ciHubPkg::*;

  delayState_t delayState;
  ciWord_t     countdown;
  ciWord_t     loadValue;
  logic        hit;
  logic        zeroDelay;
  logic        countdownEnd;

  // A start is only taken while idle
  assign hit = request.start && (request.n == `CI_DELAY_ID) && (delayState == delayIdle);

  assign zeroDelay = hit && (request.dataA == '0);
  assign loadValue = request.dataA * `CLOCKS_PER_MICROSECOND;

  // Last counting cycle
  assign countdownEnd = (delayState == delayCounting) && (countdown == 32'd1);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      delayState <= delayIdle;
      countdown  <= '0;
    end else begin
      case (delayState)
        delayIdle: begin
          if (hit && !zeroDelay) begin
            countdown  <= loadValue;
            delayState <= delayCounting;
          end
        end
        delayCounting: begin
          countdown <= countdown - 1'b1;
          if (countdownEnd) begin
            delayState <= delayIdle;
          end
        end
        default: begin
          delayState <= delayIdle;
        end
      endcase
    end
  end

  // Zero delay finishes in the start cycle
  assign done   = zeroDelay | countdownEnd;
  assign result = '0;

endmodule

/* ciHub.sv */
// Custom-instruction hub: fans processor requests out to the units and ORs their replies
`timescale 1ns/1ps

module ciHub (
  input  logic                s_systemClock,
  input  logic                s_pllLocked,
  input  logic                ciStart,
  input  ciHubPkg::ciId_t     ciN,
  input  ciHubPkg::ciWord_t   ciDataA,
  input  ciHubPkg::ciWord_t   ciDataB,
  input  logic                cpuStall,
  input  logic                busIdle,
  output logic                ciDone,
  output ciHubPkg::ciWord_t   ciResult
);
  import ciHubPkg::*;

  logic    s_grayDone;
  logic    s_profileDone;
  logic    s_delayDone;
  ciWord_t s_grayResult;
  ciWord_t s_profileResult;
  ciWord_t s_delayResult;

  ciRequestIf request ();

  assign request.start = ciStart;
  assign request.n     = ciN;
  assign request.dataA = ciDataA;
  assign request.dataB = ciDataB;

  grayscaleIse grayPixel (
    .request (request.unit),
    .done    (s_grayDone),
    .result  (s_grayResult)
  );

  profileCounters hardwareCounters (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .request       (request.unit),
    .cpuStall      (cpuStall),
    .busIdle       (busIdle),
    .done          (s_profileDone),
    .result        (s_profileResult)
  );

  microDelayIse delayMicro (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .request       (request.unit),
    .done          (s_delayDone),
    .result        (s_delayResult)
  );

  // Idle units hold zero, so a plain OR merges the replies
  assign ciDone   = s_grayDone | s_profileDone | s_delayDone;
  assign ciResult = s_grayResult | s_profileResult | s_delayResult;

endmodule

/* tbClock.sv */
// Testbench clock and reset source: 40 ns system clock, reset held low for five cycles
`timescale 1ns/1ps

module tbClock (
  output logic s_systemClock,
  output logic s_pllLocked
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES   = 5;

  initial begin
    s_systemClock = 1'b0;
    forever #(HALF_PERIOD_NS) s_systemClock = ~s_systemClock;
  end

  // Release lands on a falling edge, away from the sampling edge
  initial begin
    s_pllLocked = 1'b0;
    repeat (RESET_CYCLES) @(negedge s_systemClock);
    s_pllLocked = 1'b1;
  end

endmodule

/* ciHub_checker.sv */
// Hub output checker: concurrent assertions on done and result, bound into ciHub
`timescale 1ns/1ps
`include "ciHub_params.svh"

module ciHub_checker (
  input logic                s_systemClock,
  input logic                s_pllLocked,
  input logic                ciStart,
  input ciHubPkg::ciId_t     ciN,
  input logic                ciDone,
  input ciHubPkg::ciWord_t   ciResult
);
  import ciHubPkg::*;

  // Idle units must leave the merged result at zero
  resultZeroWhenIdle: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    !ciDone |-> (ciResult == '0)
  ) else $error("ciResult is non-zero while ciDone is low");

  donePulseOnly: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    ciDone |=> !ciDone
  ) else $error("ciDone stayed high for two cycles");

  noDoneInReset: assert property (
    @(posedge s_systemClock)
    !s_pllLocked |-> !ciDone
  ) else $error("ciDone is high during reset");

  // Gray and profile answer in the start cycle
  singleCycleDone: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    (ciStart && ((ciN == `CI_GRAY_ID) || (ciN == `CI_PROFILE_ID))) |-> ciDone
  ) else $error("gray or profile start without ciDone in the same cycle");

endmodule

bind ciHub ciHub_checker hubChecker (
  .s_systemClock (s_systemClock),
  .s_pllLocked   (s_pllLocked),
  .ciStart       (ciStart),
  .ciN           (ciN),
  .ciDone        (ciDone),
  .ciResult      (ciResult)
);

/* ciHub_tb.sv */
// Testbench for the custom-instruction hub: random requests checked against a reference model
`timescale 1ns/1ps
`include "ciHub_params.svh"

module ciHub_tb;
  import ciHubPkg::*;

  localparam int          SETTLE_NS      = 10;
  localparam int          TIMEOUT_CYCLES = 40000;
  localparam logic [31:0] RANDOM_SEED    = 32'h339e_38e2;

  logic          s_systemClock;
  logic          s_pllLocked;
  logic          ciStart;
  ciId_t         ciN;
  ciWord_t       ciDataA;
  ciWord_t       ciDataB;
  logic          cpuStall;
  logic          busIdle;
  logic          ciDone;
  ciWord_t       ciResult;

  logic          sampledDone;
  ciWord_t       sampledResult;
  ciWord_t       rngState;
  counterValue_t modelCount [4];
  logic [3:0]    modelEnabled;
  int            cycleCount;
  int            checkCount;
  int            errorCount;
  int            testsRun;
  int            testsFailed;
  int            testErrorBase;
  int            testCheckBase;

  tbClock clockGen (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked)
  );

  ciHub ciHub_i (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .cpuStall      (cpuStall),
    .busIdle       (busIdle),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

  function automatic ciWord_t xorshift32(input ciWord_t state);
    ciWord_t x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function ciWord_t randomWord();
    rngState = xorshift32(rngState);
    return rngState;
  endfunction

  // RGB565 widened to 8 bits per channel, luma weights over 256
  function automatic grayValue_t expectedGray(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    red   = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue  = int'(pixel[4:0]) * 8;
    return grayValue_t'((54 * red + 183 * green + 19 * blue) / 256);
  endfunction

  function automatic logic counterEvent(input int index, input logic stall, input logic idle);
    case (index)
      1:       return stall;
      2:       return idle;
      default: return 1'b1;
    endcase
  endfunction

  // One clock: drive on the falling edge, sample, then step the model past the rising edge
  task automatic runCycle(input logic start, input ciId_t n, input ciWord_t a, input ciWord_t b);
    ciWord_t noise;
    logic    profileHit;
    noise = randomWord();
    @(negedge s_systemClock);
    ciStart  = start;
    ciN      = n;
    ciDataA  = a;
    ciDataB  = b;
    cpuStall = noise[0];
    busIdle  = noise[1];
    #(SETTLE_NS);
    sampledDone   = ciDone;
    sampledResult = ciResult;
    profileHit = start && (n == `CI_PROFILE_ID);
    for (int i = 0; i < 4; i++) begin
      if (profileHit && b[`PROFILE_CLEAR_LSB + i]) begin
        modelCount[i] = '0;
      end else if (modelEnabled[i] && counterEvent(i, noise[0], noise[1])) begin
        modelCount[i] = modelCount[i] + 1;
      end
    end
    if (profileHit) begin
      modelEnabled = (modelEnabled | b[`PROFILE_ENABLE_LSB +: 4]) & ~b[`PROFILE_DISABLE_LSB +: 4];
    end
  endtask

  task automatic idleCycles(input int count);
    for (int i = 0; i < count; i++) begin
      runCycle(1'b0, 8'd0, '0, '0);
    end
  endtask

  task automatic checkValue(input string what, input ciWord_t actual, input ciWord_t expected);
    checkCount++;
    assert (actual === expected) else begin
      errorCount++;
      $display("error at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Profile read of one counter, compared with the model value before the command
  task automatic readCounter(input int index);
    counterValue_t expected;
    expected = modelCount[index];
    runCycle(1'b1, `CI_PROFILE_ID, ciWord_t'(index), '0);
    checkValue($sformatf("profile done, counter %0d", index), ciWord_t'(sampledDone), 32'd1);
    checkValue($sformatf("counter %0d", index), sampledResult, expected);
    idleCycles(1);
  endtask

  task automatic beginTest();
    testErrorBase = errorCount;
    testCheckBase = checkCount;
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (errorCount == testErrorBase) begin
      $display("test %s: ok, %0d checks", name, checkCount - testCheckBase);
    end else begin
      testsFailed++;
      $display("test %s: %0d errors", name, errorCount - testErrorBase);
    end
  endtask

  // Whole run is a few thousand cycles
  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES) begin
      @(posedge s_systemClock);
      cycleCount++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin : stimulus
    ciWord_t    word;
    ciWord_t    micros;
    int         latency;
    int         waited;
    int         span;
    logic       finished;
    logic       doneSeen;
    ciStart      = 1'b0;
    ciN          = '0;
    ciDataA      = '0;
    ciDataB      = '0;
    cpuStall     = 1'b0;
    busIdle      = 1'b0;
    rngState     = RANDOM_SEED;
    modelEnabled = '0;
    checkCount   = 0;
    errorCount   = 0;
    testsRun     = 0;
    testsFailed  = 0;
    for (int i = 0; i < 4; i++) begin
      modelCount[i] = '0;
    end
    wait (s_pllLocked === 1'b1);

    beginTest();
    idleCycles(1);
    checkValue("ciDone after reset", ciWord_t'(sampledDone), 32'd0);
    checkValue("ciResult after reset", sampledResult, 32'd0);
    for (int i = 0; i < 4; i++) begin
      readCounter(i);
    end
    endTest("reset");

    beginTest();
    for (int i = 0; i < 200; i++) begin
      word = randomWord();
      runCycle(1'b1, `CI_GRAY_ID, word, randomWord());
      checkValue("gray done", ciWord_t'(sampledDone), 32'd1);
      checkValue("gray result", sampledResult, ciWord_t'(expectedGray(word[15:0])));
      idleCycles(1);
    end
    endTest("grayscale");

    beginTest();
    for (int round = 0; round < 4; round++) begin
      runCycle(1'b1, `CI_PROFILE_ID, '0, 32'h0000_0009);
      idleCycles(1 + int'(randomWord() % 64));
      runCycle(1'b1, `CI_PROFILE_ID, '0, 32'h0000_0090);
      idleCycles(1 + int'(randomWord() % 4));
      readCounter(0);
      readCounter(3);
      runCycle(1'b1, `CI_PROFILE_ID, '0, 32'h0000_0900);
      idleCycles(1);
      readCounter(0);
      readCounter(3);
    end
    endTest("cycle counters");

    beginTest();
    for (int round = 0; round < 3; round++) begin
      // Clear and enable together
      runCycle(1'b1, `CI_PROFILE_ID, '0, 32'h0000_0606);
      span = 50 + int'(randomWord() % 100);
      idleCycles(span);
      readCounter(1);
      idleCycles(span / 2);
      runCycle(1'b1, `CI_PROFILE_ID, '0, 32'h0000_0060);
      idleCycles(1);
      readCounter(1);
      readCounter(2);
    end
    endTest("event counters");

    beginTest();
    for (int k = 0; k < 20; k++) begin
      micros  = randomWord() % 9;
      latency = int'(micros) * int'(`CLOCKS_PER_MICROSECOND);
      runCycle(1'b1, `CI_DELAY_ID, micros, randomWord());
      if (micros == 0) begin
        checkValue("zero delay done", ciWord_t'(sampledDone), 32'd1);
        checkValue("zero delay result", sampledResult, 32'd0);
      end else begin
        checkValue("delay done in start cycle", ciWord_t'(sampledDone), 32'd0);
        waited   = 0;
        finished = 1'b0;
        while (!finished && waited < latency + 20) begin
          idleCycles(1);
          waited++;
          finished = sampledDone;
        end
        checkCount++;
        assert (finished) else begin
          errorCount++;
          $display("delay of %0d us never raised done within %0d cycles", micros, waited);
        end
        if (finished) begin
          checkValue("delay latency", ciWord_t'(waited), ciWord_t'(latency));
          checkValue("delay result", sampledResult, 32'd0);
        end
      end
      idleCycles(1);
    end
    endTest("micro delay");

    beginTest();
    runCycle(1'b1, 8'd3, randomWord(), randomWord());
    doneSeen = sampledDone;
    for (int i = 0; i < 50; i++) begin
      idleCycles(1);
      doneSeen = doneSeen | sampledDone;
    end
    checkCount++;
    assert (!doneSeen) else begin
      errorCount++;
      $display("unused instruction number 3 raised done within 50 cycles");
    end
    endTest("unknown instruction");

    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             testsRun, testsFailed, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* ciHub.f */
+incdir+.
ciHubPkg.sv
ciRequestIf.sv
grayscaleIse.sv
profileCounters.sv
microDelayIse.sv
ciHub.sv
tbClock.sv
ciHub_checker.sv
ciHub_tb.sv

/* run.sh */
#!/bin/sh
# Builds the ciHub testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module ciHub_tb -f ciHub.f
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "verilator build failed with status $buildStatus"
  exit 1
fi

simOutput=$(./obj_dir/VciHub_tb)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "TB PASSED"; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1
